// File: design/memtest_macros.svh
`ifndef MEMTEST_MACROS_SVH
`define MEMTEST_MACROS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define MT_ADDR_W 33
`define MT_DATA_W 256

// ------------------------------
// tested address window
// ------------------------------
// first byte address written
`define MT_START_ADRS 33'h0_0000_0000
// exclusive end address
`define MT_STOP_ADRS 33'h0_0000_0400
// one column per slot
`define MT_ADRS_STEP 33'd4
`define MT_SLOT_COUNT (int'((`MT_STOP_ADRS - `MT_START_ADRS) / `MT_ADRS_STEP))
// base word mixed into every pattern
`define MT_PATTERN_SEED 16'h1234

`endif

// File: design/memtest_pkg.sv
package memtest_pkg;

`include "memtest_macros.svh"

	// ------------------------------
	// plain vectors
	// ------------------------------
	typedef logic [`MT_ADDR_W-1:0] axi_addr_t;
	typedef logic [`MT_DATA_W-1:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [15:0] pattern_t;
	typedef logic [15:0] slot_idx_t;

	// ddr controller address layout
	typedef struct packed
	{
		logic cs;
		logic [16:0] row;
		logic [2:0] bank;
		logic [9:0] col;
		logic [1:0] datapath;
	} ddr_addr_t;

	// one read beat as seen on the r channel
	typedef struct packed
	{
		axi_data_t data;
		axi_resp_t resp;
		logic last;
	} axi_r_t;

	// tester status flags
	typedef struct packed
	{
		logic run;
		logic done;
		logic fail;
	} mt_status_t;

	typedef enum logic [2:0]
	{
		IDLE,
		WRITE_CMD,
		WRITE_WAIT,
		READ_CMD,
		READ_WAIT,
		DONE
	} mt_state_e;

	// slot index xor seed, rotated left by idx[3:0]
	function automatic pattern_t pattern_of(input slot_idx_t idx);
		pattern_t base;
		logic [31:0] dbl;
		base = pattern_t'(idx) ^ `MT_PATTERN_SEED;
		// upper half of the doubled word holds the rotation
		dbl = {base, base} << idx[3:0];
		return dbl[31:16];
	endfunction

endpackage

// File: design/memtest_fsm.sv
`timescale 1ns/1ps

module memtest_fsm
(
	input logic iAxiCLK,
	input logic iAxiRST,
	input logic i_cfg_done,
	input logic i_wr_done,
	input logic i_wr_err,
	input logic i_rd_done,
	input logic i_rd_bad,
	input logic i_slot_last,
	input memtest_pkg::ddr_addr_t i_slot_addr,
	output logic o_wr_start,
	output logic o_rd_start,
	output logic o_slot_next,
	output logic o_slot_clear,
	output memtest_pkg::mt_status_t o_status,
	output memtest_pkg::axi_addr_t o_fail_addr
);

	memtest_pkg::mt_state_e state;
	memtest_pkg::mt_state_e state_nxt;
	// end of test events
	logic finish_pass;
	logic finish_fail;

	// ------------------------------
	// next state and pulses
	// ------------------------------
	always_comb
	begin
		state_nxt = state;
		o_wr_start = 1'b0;
		o_rd_start = 1'b0;
		o_slot_next = 1'b0;
		o_slot_clear = 1'b0;
		finish_pass = 1'b0;
		finish_fail = 1'b0;
		case (state)
			memtest_pkg::IDLE:
			begin
				// wait for ddr controller init
				if (i_cfg_done)
					state_nxt = memtest_pkg::WRITE_CMD;
			end
			memtest_pkg::WRITE_CMD:
			begin
				o_wr_start = 1'b1;
				state_nxt = memtest_pkg::WRITE_WAIT;
			end
			memtest_pkg::WRITE_WAIT:
			begin
				if (i_wr_done)
				begin
					if (i_wr_err)
					begin
						// bad bresp aborts before any read
						finish_fail = 1'b1;
						state_nxt = memtest_pkg::DONE;
					end
					else if (i_slot_last)
					begin
						// rewind counter for read phase
						o_slot_clear = 1'b1;
						state_nxt = memtest_pkg::READ_CMD;
					end
					else
					begin
						o_slot_next = 1'b1;
						state_nxt = memtest_pkg::WRITE_CMD;
					end
				end
			end
			memtest_pkg::READ_CMD:
			begin
				o_rd_start = 1'b1;
				state_nxt = memtest_pkg::READ_WAIT;
			end
			memtest_pkg::READ_WAIT:
			begin
				if (i_rd_done)
				begin
					if (i_rd_bad)
					begin
						finish_fail = 1'b1;
						state_nxt = memtest_pkg::DONE;
					end
					else if (i_slot_last)
					begin
						finish_pass = 1'b1;
						state_nxt = memtest_pkg::DONE;
					end
					else
					begin
						o_slot_next = 1'b1;
						state_nxt = memtest_pkg::READ_CMD;
					end
				end
			end
			memtest_pkg::DONE:
			begin
				// held here until reset
				state_nxt = memtest_pkg::DONE;
			end
			default:
			begin
				state_nxt = memtest_pkg::IDLE;
			end
		endcase
	end

	// ------------------------------
	// state and status registers
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			state <= memtest_pkg::IDLE;
			o_status <= '0;
			o_fail_addr <= '0;
		end
		else
		begin
			state <= state_nxt;
			// run rises on leaving idle
			if (state == memtest_pkg::IDLE && i_cfg_done)
				o_status.run <= 1'b1;
			if (finish_pass || finish_fail)
			begin
				o_status.run <= 1'b0;
				o_status.done <= 1'b1;
			end
			// capture the slot still on the counter
			if (finish_fail)
			begin
				o_status.fail <= 1'b1;
				o_fail_addr <= memtest_pkg::axi_addr_t'(i_slot_addr);
			end
		end
	end

endmodule

// File: design/memtest_addr_counter.sv
`timescale 1ns/1ps

`include "memtest_macros.svh"

module memtest_addr_counter
(
	input logic iAxiCLK,
	input logic iAxiRST,
	input logic i_clear,
	input logic i_next,
	output memtest_pkg::slot_idx_t o_slot_idx,
	output memtest_pkg::ddr_addr_t o_slot_addr,
	output logic o_slot_last
);

	// running byte address of the current slot
	memtest_pkg::axi_addr_t addr_sum;
	memtest_pkg::slot_idx_t slot_idx;

	// ------------------------------
	// index and address
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST || i_clear)
		begin
			slot_idx <= '0;
			addr_sum <= `MT_START_ADRS;
		end
		else if (i_next)
		begin
			slot_idx <= slot_idx + 1'b1;
			// start + idx * step without a multiplier
			addr_sum <= addr_sum + `MT_ADRS_STEP;
		end
	end

	assign o_slot_idx = slot_idx;

	// ------------------------------
	// split into ddr fields
	// ------------------------------
	always_comb
	begin
		// chip select on top bit
		o_slot_addr.cs = addr_sum[32];
		o_slot_addr.row = addr_sum[31:15];
		o_slot_addr.bank = addr_sum[14:12];
		o_slot_addr.col = addr_sum[11:2];
		// byte lanes within a beat unused
		o_slot_addr.datapath = 2'b00;
	end

	// final slot of the window
	assign o_slot_last = (slot_idx == memtest_pkg::slot_idx_t'(`MT_SLOT_COUNT - 1));

endmodule

// File: design/memtest_write_channel.sv
`timescale 1ns/1ps

module memtest_write_channel
(
	input logic iAxiCLK,
	input logic iAxiRST,
	input logic i_start,
	input memtest_pkg::ddr_addr_t i_addr,
	input memtest_pkg::slot_idx_t i_idx,
	input logic i_awready,
	input logic i_wready,
	input memtest_pkg::axi_resp_t i_bresp,
	input logic i_bvalid,
	output memtest_pkg::axi_addr_t o_awaddr,
	output logic o_awvalid,
	output memtest_pkg::axi_data_t o_wdata,
	output logic o_wvalid,
	output logic o_bready,
	output logic o_done,
	output logic o_err
);

	// handshakes this cycle
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	// last of aw and w completes now
	logic req_sent;

	assign aw_hs = o_awvalid && i_awready;
	assign w_hs = o_wvalid && i_wready;
	assign b_hs = o_bready && i_bvalid;
	// some valid still up and none left after this edge
	assign req_sent = (o_awvalid || o_wvalid) && (!o_awvalid || aw_hs) && (!o_wvalid || w_hs);

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (i_start)
		begin
			o_awaddr <= memtest_pkg::axi_addr_t'(i_addr);
			// pattern in low bits, rest zero
			o_wdata <= memtest_pkg::axi_data_t'(memtest_pkg::pattern_of(i_idx));
		end
	end

	// ------------------------------
	// valid / ready control
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			o_awvalid <= 1'b0;
			o_wvalid <= 1'b0;
			o_bready <= 1'b0;
			o_done <= 1'b0;
			o_err <= 1'b0;
		end
		else
		begin
			// single cycle
			o_done <= 1'b0;
			if (i_start)
			begin
				o_awvalid <= 1'b1;
				o_wvalid <= 1'b1;
				o_err <= 1'b0;
			end
			else
			begin
				// aw and w drop independently
				if (aw_hs)
					o_awvalid <= 1'b0;
				if (w_hs)
					o_wvalid <= 1'b0;
			end
			if (req_sent)
				o_bready <= 1'b1;
			if (b_hs)
			begin
				o_bready <= 1'b0;
				o_done <= 1'b1;
				// slverr or decerr
				o_err <= i_bresp[1];
			end
		end
	end

endmodule

// File: design/memtest_read_channel.sv
`timescale 1ns/1ps

`include "memtest_macros.svh"

module memtest_read_channel
(
	input logic iAxiCLK,
	input logic iAxiRST,
	input logic i_start,
	input memtest_pkg::ddr_addr_t i_addr,
	input memtest_pkg::slot_idx_t i_idx,
	input logic i_arready,
	input memtest_pkg::axi_r_t i_r,
	input logic i_rvalid,
	output memtest_pkg::axi_addr_t o_araddr,
	output logic o_arvalid,
	output logic o_rready,
	output logic o_done,
	output logic o_bad
);

	localparam int pat_w = $bits(memtest_pkg::pattern_t);

	// expected word for this slot
	memtest_pkg::pattern_t exp_pattern;
	logic ar_hs;
	logic r_hs;
	// per-beat checks
	logic low_bad;
	logic high_bad;
	logic resp_bad;
	logic last_bad;
	logic beat_bad;

	assign ar_hs = o_arvalid && i_arready;
	assign r_hs = o_rready && i_rvalid;

	// ------------------------------
	// beat compare
	// ------------------------------
	always_comb
	begin
		// pattern lanes
		low_bad = (i_r.data[pat_w-1:0] != exp_pattern);
		// everything above the pattern must read zero
		high_bad = |i_r.data[`MT_DATA_W-1:pat_w];
		resp_bad = i_r.resp[1];
		// single beat so last must be set
		last_bad = !i_r.last;
		beat_bad = low_bad || high_bad || resp_bad || last_bad;
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (i_start)
		begin
			o_araddr <= memtest_pkg::axi_addr_t'(i_addr);
			exp_pattern <= memtest_pkg::pattern_of(i_idx);
		end
	end

	// ------------------------------
	// ar / r control
	// ------------------------------
	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			o_arvalid <= 1'b0;
			o_rready <= 1'b0;
			o_done <= 1'b0;
			o_bad <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start)
			begin
				o_arvalid <= 1'b1;
				o_bad <= 1'b0;
			end
			// ready for data once the address is taken
			if (ar_hs)
			begin
				o_arvalid <= 1'b0;
				o_rready <= 1'b1;
			end
			if (r_hs)
			begin
				o_rready <= 1'b0;
				o_done <= 1'b1;
				o_bad <= beat_bad;
			end
		end
	end

endmodule

// File: design/memory_checker.sv
`timescale 1ns/1ps

module memory_checker
(
	// write address
	output memtest_pkg::axi_addr_t o_awaddr,
	output logic o_awvalid,
	input logic i_awready,
	// write data
	output memtest_pkg::axi_data_t o_wdata,
	output logic o_wvalid,
	input logic i_wready,
	// write response
	input memtest_pkg::axi_resp_t i_bresp,
	input logic i_bvalid,
	output logic o_bready,
	// read address
	output memtest_pkg::axi_addr_t o_araddr,
	output logic o_arvalid,
	input logic i_arready,
	// read data
	input memtest_pkg::axi_r_t i_r,
	input logic i_rvalid,
	output logic o_rready,
	// test control and status
	input logic i_cfg_done,
	output memtest_pkg::mt_status_t o_status,
	output memtest_pkg::axi_addr_t o_fail_addr,
	input logic iAxiCLK,
	input logic iAxiRST
);

	// ------------------------------
	// fsm to channel pulses
	// ------------------------------
	logic wr_start;
	logic rd_start;
	logic wr_done;
	logic wr_err;
	logic rd_done;
	logic rd_bad;
	// counter control and slot info
	logic slot_next;
	logic slot_clear;
	logic slot_last;
	memtest_pkg::slot_idx_t slot_idx;
	memtest_pkg::ddr_addr_t slot_addr;

	memtest_fsm u_fsm
	(
		.iAxiCLK(iAxiCLK),
		.iAxiRST(iAxiRST),
		.i_cfg_done(i_cfg_done),
		.i_wr_done(wr_done),
		.i_wr_err(wr_err),
		.i_rd_done(rd_done),
		.i_rd_bad(rd_bad),
		.i_slot_last(slot_last),
		.i_slot_addr(slot_addr),
		.o_wr_start(wr_start),
		.o_rd_start(rd_start),
		.o_slot_next(slot_next),
		.o_slot_clear(slot_clear),
		.o_status(o_status),
		.o_fail_addr(o_fail_addr)
	);

	memtest_addr_counter u_counter
	(
		.iAxiCLK(iAxiCLK),
		.iAxiRST(iAxiRST),
		.i_clear(slot_clear),
		.i_next(slot_next),
		.o_slot_idx(slot_idx),
		.o_slot_addr(slot_addr),
		.o_slot_last(slot_last)
	);

	// aw, w and b
	memtest_write_channel u_wr
	(
		.iAxiCLK(iAxiCLK),
		.iAxiRST(iAxiRST),
		.i_start(wr_start),
		.i_addr(slot_addr),
		.i_idx(slot_idx),
		.i_awready(i_awready),
		.i_wready(i_wready),
		.i_bresp(i_bresp),
		.i_bvalid(i_bvalid),
		.o_awaddr(o_awaddr),
		.o_awvalid(o_awvalid),
		.o_wdata(o_wdata),
		.o_wvalid(o_wvalid),
		.o_bready(o_bready),
		.o_done(wr_done),
		.o_err(wr_err)
	);

	// ar and r
	memtest_read_channel u_rd
	(
		.iAxiCLK(iAxiCLK),
		.iAxiRST(iAxiRST),
		.i_start(rd_start),
		.i_addr(slot_addr),
		.i_idx(slot_idx),
		.i_arready(i_arready),
		.i_r(i_r),
		.i_rvalid(i_rvalid),
		.o_araddr(o_araddr),
		.o_arvalid(o_arvalid),
		.o_rready(o_rready),
		.o_done(rd_done),
		.o_bad(rd_bad)
	);

endmodule

// File: test/tb_axi_mem_model.sv
`timescale 1ns/1ps

`include "memtest_macros.svh"

module tb_axi_mem_model
(
	input logic iAxiCLK,
	input logic iAxiRST,
	// pacing and fault injection
	input logic i_stall,
	input logic i_corrupt_en,
	input int i_corrupt_slot,
	input logic i_err_en,
	input int i_err_slot,
	// aw, w and b
	input memtest_pkg::axi_addr_t i_awaddr,
	input logic i_awvalid,
	output logic o_awready,
	input memtest_pkg::axi_data_t i_wdata,
	input logic i_wvalid,
	output logic o_wready,
	output memtest_pkg::axi_resp_t o_bresp,
	output logic o_bvalid,
	input logic i_bready,
	// ar and r
	input memtest_pkg::axi_addr_t i_araddr,
	input logic i_arvalid,
	output logic o_arready,
	output memtest_pkg::axi_r_t o_r,
	output logic o_rvalid,
	input logic i_rready
);

	// one bus word per slot
	memtest_pkg::axi_data_t mem [0:`MT_SLOT_COUNT-1];
	// accepted, not yet answered
	logic aw_pend;
	logic w_pend;
	logic ar_pend;
	memtest_pkg::axi_addr_t aw_addr;
	memtest_pkg::axi_data_t w_data;
	memtest_pkg::axi_addr_t ar_addr;

	function automatic int slot_of(input memtest_pkg::axi_addr_t addr);
		return int'((addr - `MT_START_ADRS) / `MT_ADRS_STEP);
	endfunction

	// stalled mode moves on one cycle in four
	function automatic logic may_move();
		return !i_stall || ($urandom % 4 == 0);
	endfunction

	// defined levels before the first reset edge
	initial
	begin
		o_awready = 1'b0;
		o_wready = 1'b0;
		o_arready = 1'b0;
		o_bvalid = 1'b0;
		o_bresp = '0;
		o_rvalid = 1'b0;
		o_r = '0;
	end

	always @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
			o_bvalid <= 1'b0;
			o_bresp <= '0;
			o_rvalid <= 1'b0;
			o_r <= '0;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			ar_pend <= 1'b0;
			// fill word follows the whole slot index
			for (int i = 0; i < `MT_SLOT_COUNT; i++)
				mem[i] <= {8{32'(i) ^ 32'h5ac3_3ca5}};
		end
		else
		begin
			o_awready <= !aw_pend && may_move();
			o_wready <= !w_pend && may_move();
			o_arready <= !ar_pend && may_move();
			// ------------------------------
			// write side
			// ------------------------------
			if (i_awvalid && o_awready)
			begin
				aw_pend <= 1'b1;
				aw_addr <= i_awaddr;
			end
			if (i_wvalid && o_wready)
			begin
				w_pend <= 1'b1;
				w_data <= i_wdata;
			end
			if (aw_pend && w_pend && !o_bvalid && may_move())
			begin
				mem[slot_of(aw_addr)] <= w_data;
				// slverr on the chosen slot
				o_bresp <= (i_err_en && slot_of(aw_addr) == i_err_slot) ? 2'b10 : 2'b00;
				o_bvalid <= 1'b1;
				aw_pend <= 1'b0;
				w_pend <= 1'b0;
			end
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			// ------------------------------
			// read side
			// ------------------------------
			if (i_arvalid && o_arready)
			begin
				ar_pend <= 1'b1;
				ar_addr <= i_araddr;
			end
			if (ar_pend && !o_rvalid && may_move())
			begin
				// flip bit 0 on the corrupted slot
				o_r.data <= mem[slot_of(ar_addr)] ^ memtest_pkg::axi_data_t'(i_corrupt_en
					&& slot_of(ar_addr) == i_corrupt_slot);
				o_r.resp <= 2'b00;
				o_r.last <= 1'b1;
				o_rvalid <= 1'b1;
				ar_pend <= 1'b0;
			end
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
		end
	end

endmodule

// File: test/tb_memory_checker.sv
`timescale 1ns/1ps

`include "memtest_macros.svh"

module tb_memory_checker;

	localparam int slot_cnt = `MT_SLOT_COUNT;
	// worst case cycles per slot and phase, stalls included
	localparam int slot_cycles = 64;
	localparam int test_cnt = 6;
	localparam int run_cycles = 2 * slot_cnt * slot_cycles;
	localparam longint limit_ns = longint'(test_cnt) * run_cycles * 8;

	logic axi_clk;
	logic axi_rst;
	logic cfg_done;
	// model pacing and faults
	logic stall;
	logic corrupt_en;
	int corrupt_slot;
	logic err_en;
	int err_slot;
	// ------------------------------
	// dut bus
	// ------------------------------
	memtest_pkg::axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	memtest_pkg::axi_data_t wdata;
	logic wvalid;
	logic wready;
	memtest_pkg::axi_resp_t bresp;
	logic bvalid;
	logic bready;
	memtest_pkg::axi_addr_t araddr;
	logic arvalid;
	logic arready;
	memtest_pkg::axi_r_t r_beat;
	logic rvalid;
	logic rready;
	memtest_pkg::mt_status_t status;
	memtest_pkg::axi_addr_t fail_addr;
	// compare process state
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int wr_count;
	int rd_count;
	memtest_pkg::axi_addr_t max_rd_addr;
	logic aw_wait;
	logic w_wait;
	logic ar_wait;
	memtest_pkg::axi_addr_t aw_hold;
	memtest_pkg::axi_data_t w_hold;
	memtest_pkg::axi_addr_t ar_hold;

	memory_checker uut
	(
		.o_awaddr(awaddr),
		.o_awvalid(awvalid),
		.i_awready(awready),
		.o_wdata(wdata),
		.o_wvalid(wvalid),
		.i_wready(wready),
		.i_bresp(bresp),
		.i_bvalid(bvalid),
		.o_bready(bready),
		.o_araddr(araddr),
		.o_arvalid(arvalid),
		.i_arready(arready),
		.i_r(r_beat),
		.i_rvalid(rvalid),
		.o_rready(rready),
		.i_cfg_done(cfg_done),
		.o_status(status),
		.o_fail_addr(fail_addr),
		.iAxiCLK(axi_clk),
		.iAxiRST(axi_rst)
	);

	tb_axi_mem_model mem_model
	(
		.iAxiCLK(axi_clk),
		.iAxiRST(axi_rst),
		.i_stall(stall),
		.i_corrupt_en(corrupt_en),
		.i_corrupt_slot(corrupt_slot),
		.i_err_en(err_en),
		.i_err_slot(err_slot),
		.i_awaddr(awaddr),
		.i_awvalid(awvalid),
		.o_awready(awready),
		.i_wdata(wdata),
		.i_wvalid(wvalid),
		.o_wready(wready),
		.o_bresp(bresp),
		.o_bvalid(bvalid),
		.i_bready(bready),
		.i_araddr(araddr),
		.i_arvalid(arvalid),
		.o_arready(arready),
		.o_r(r_beat),
		.o_rvalid(rvalid),
		.i_rready(rready)
	);

	initial
	begin
		axi_clk = 1'b0;
		forever #4 axi_clk = ~axi_clk;
	end

	// slot index xor seed, rotated left by the low four index bits
	function automatic logic [15:0] expected_word(input int idx);
		logic [15:0] base;
		int rot;
		base = idx[15:0] ^ `MT_PATTERN_SEED;
		rot = idx % 16;
		if (rot == 0)
			return base;
		return (base << rot) | (base >> (16 - rot));
	endfunction

	function automatic memtest_pkg::axi_addr_t addr_of(input int idx);
		return `MT_START_ADRS + memtest_pkg::axi_addr_t'(idx) * `MT_ADRS_STEP;
	endfunction

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// ------------------------------
	// compare process
	// ------------------------------
	always @(posedge axi_clk)
	begin
		if (axi_rst)
		begin
			wr_count <= 0;
			rd_count <= 0;
			max_rd_addr <= '0;
			aw_wait <= 1'b0;
			w_wait <= 1'b0;
			ar_wait <= 1'b0;
		end
		else
		begin
			if (awvalid && awready)
				wr_count <= wr_count + 1;
			if (arvalid && arready)
			begin
				rd_count <= rd_count + 1;
				if (araddr > max_rd_addr)
					max_rd_addr <= araddr;
			end
			// run spans the whole pass and ends when done rises
			if (status.run && status.done)
				report_error("run and done high together");
			if ((awvalid || wvalid || arvalid) && !status.run)
				report_error("bus request issued while run is low");
			// a waiting valid keeps itself and its payload
			if (aw_wait && (!awvalid || awaddr !== aw_hold))
				report_error("awvalid or awaddr changed before the handshake");
			if (w_wait && (!wvalid || wdata !== w_hold))
				report_error("wvalid or wdata changed before the handshake");
			if (ar_wait && (!arvalid || araddr !== ar_hold))
				report_error("arvalid or araddr changed before the handshake");
			aw_wait <= awvalid && !awready;
			w_wait <= wvalid && !wready;
			ar_wait <= arvalid && !arready;
			aw_hold <= awaddr;
			w_hold <= wdata;
			ar_hold <= araddr;
		end
	end

	task automatic apply_reset();
		axi_rst <= 1'b1;
		cfg_done <= 1'b0;
		repeat (2) @(posedge axi_clk);
		axi_rst <= 1'b0;
	endtask

	task automatic start_run(input logic stall_i, input logic cor_en, input int cor_slot,
		input logic er_en, input int er_slot);
		stall <= stall_i;
		corrupt_en <= cor_en;
		corrupt_slot <= cor_slot;
		err_en <= er_en;
		err_slot <= er_slot;
		apply_reset();
		cfg_done <= 1'b1;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!status.done && n < run_cycles)
		begin
			@(posedge axi_clk);
			n++;
		end
		if (!status.done)
		begin
			$display("done never rose within %0d cycles", run_cycles);
			error_count++;
		end
	endtask

	task automatic check_memory();
		memtest_pkg::axi_data_t exp_word;
		for (int i = 0; i < slot_cnt; i++)
		begin
			exp_word = memtest_pkg::axi_data_t'(expected_word(i));
			if (mem_model.mem[i] !== exp_word)
				report_error($sformatf("slot %0d holds %h, expected %h", i,
					mem_model.mem[i], exp_word));
		end
	endtask

	// full write and read pass with no faults
	task automatic clean_run(input logic stall_i);
		start_run(stall_i, 1'b0, 0, 1'b0, 0);
		wait_done();
		if (!status.done || status.fail)
			report_error("clean run did not end with done high and fail low");
		check_memory();
		if (wr_count != slot_cnt)
			report_error($sformatf("%0d writes, expected %0d", wr_count, slot_cnt));
		if (rd_count != slot_cnt)
			report_error($sformatf("%0d reads, expected %0d", rd_count, slot_cnt));
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (error_count == err_before)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: failed", name);
			tests_failed++;
		end
	endtask

	initial
	begin
		int err_before;
		int slot;
		int n;
		void'($urandom(32'hfd9a_9731));
		axi_rst = 1'b1;
		cfg_done = 1'b0;
		stall = 1'b0;
		corrupt_en = 1'b0;
		corrupt_slot = 0;
		err_en = 1'b0;
		err_slot = 0;

		// idle until cfg_done
		err_before = error_count;
		apply_reset();
		repeat (5 + int'($urandom % 20))
		begin
			@(posedge axi_clk);
			if (status.run || status.done || awvalid || wvalid || arvalid || bready || rready)
				report_error("DUT left idle while cfg_done was low");
		end
		end_test("hold before config", err_before);

		err_before = error_count;
		clean_run(1'b0);
		end_test("clean pass", err_before);

		// one flipped bit on a random slot
		err_before = error_count;
		slot = int'($urandom % slot_cnt);
		start_run(1'b0, 1'b1, slot, 1'b0, 0);
		wait_done();
		if (!status.fail)
			report_error("corrupted read was not flagged");
		if (fail_addr !== addr_of(slot))
			report_error($sformatf("fail address %h, expected %h", fail_addr, addr_of(slot)));
		if (max_rd_addr !== addr_of(slot))
			report_error($sformatf("highest read %h, expected %h", max_rd_addr, addr_of(slot)));
		end_test("read corruption", err_before);

		// slverr on a random write
		err_before = error_count;
		slot = int'($urandom % slot_cnt);
		start_run(1'b0, 1'b0, 0, 1'b1, slot);
		wait_done();
		if (!status.fail)
			report_error("write error response was not flagged");
		if (fail_addr !== addr_of(slot))
			report_error($sformatf("fail address %h, expected %h", fail_addr, addr_of(slot)));
		if (wr_count != slot + 1 || rd_count != 0)
			report_error($sformatf("%0d writes and %0d reads after write error", wr_count,
				rd_count));
		end_test("write error", err_before);

		err_before = error_count;
		clean_run(1'b1);
		end_test("back-pressure", err_before);

		// reset while reads are in flight
		err_before = error_count;
		start_run(1'b0, 1'b0, 0, 1'b0, 0);
		n = 0;
		while (!arvalid && n < run_cycles)
		begin
			@(posedge axi_clk);
			n++;
		end
		if (!arvalid)
		begin
			$display("read phase never started before the mid-run reset");
			error_count++;
		end
		repeat (10 + int'($urandom % 40)) @(posedge axi_clk);
		apply_reset();
		if (status !== '0 || fail_addr !== '0 || awvalid || wvalid || bready || arvalid
			|| rready)
			report_error("outputs not at reset values after mid-run reset");
		clean_run(1'b0);
		end_test("reset mid-run", err_before);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// ------------------------------
	// watchdog
	// ------------------------------
	initial
	begin
		#(limit_ns);
		$display("simulation ran past its %0d ns limit", limit_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: memtest.f
+incdir+design
design/memtest_pkg.sv
design/memtest_fsm.sv
design/memtest_addr_counter.sv
design/memtest_write_channel.sv
design/memtest_read_channel.sv
design/memory_checker.sv
test/tb_axi_mem_model.sv
test/tb_memory_checker.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_memory_checker
FLIST ?= memtest.f
SEED ?= 1
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   print this list"
	@echo "variables: VERILATOR TOP FLIST SEED LOG OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no verdict found in $(LOG)"; exit 1)
	@echo "no failure found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
